//--- verilog/chol_pkg.sv
package chol_pkg;

    // ====================
    // Word format
    // ====================
    localparam int WORD_W    = 32;          // Signed Q16.16
    localparam int FRAC_BITS = 16;
    localparam int ACC_W     = 2 * WORD_W;  // Full product width

    // ====================
    // Matrix size
    // ====================
    localparam int N        = 4;                // Matrix order, works for 2 to 6
    localparam int NUM_ELEM = N * (N + 1) / 2;  // Lower triangle elements
    localparam int IDX_W    = $clog2(NUM_ELEM); // Index into the triangle
    localparam int RC_W     = $clog2(N);        // Row, column and k counters

    // ====================
    // Iterative units
    // ====================
    localparam int SQRT_ITER  = WORD_W - FRAC_BITS / 2; // One root bit per cycle
    localparam int SQRT_CNT_W = $clog2(SQRT_ITER);
    localparam int SQRT_REM_W = SQRT_ITER + 6;          // Signed partial remainder
    localparam int DIV_ITER   = WORD_W + FRAC_BITS;     // One quotient bit per cycle
    localparam int DIV_CNT_W  = $clog2(DIV_ITER);

    typedef logic signed [WORD_W-1:0] word_t;

    // Element (i,j), 1-based with i >= j, sits at i(i-1)/2 + j - 1
    typedef word_t [NUM_ELEM-1:0] tri_mat_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef struct packed {
        word_t dividend;
        word_t divisor;   // Always positive
    } div_op_t;

    // Triangle position of a 0-based row and column
    function automatic logic [IDX_W-1:0] tri_idx(input logic [RC_W-1:0] row,
                                                 input logic [RC_W-1:0] col);
        int unsigned r;
        r = row;
        return IDX_W'(r * (r + 1) / 2 + col);
    endfunction

endpackage

//--- verilog/fix_sqrt.sv
module fix_sqrt
    import chol_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  sqrt_req,
    input  word_t sqrt_in,
    output logic  sqrt_ack,
    output word_t sqrt_out
);

    logic                         busy;
    logic                         start;
    logic [SQRT_CNT_W-1:0]        cnt;
    logic [2*SQRT_ITER-1:0]       rad;     // Radicand, two bits consumed per step
    logic [SQRT_ITER-1:0]         root;
    logic signed [SQRT_REM_W-1:0] rem;
    logic signed [SQRT_REM_W-1:0] rem_sh;
    logic signed [SQRT_REM_W-1:0] rem_nx;

    assign start    = sqrt_req && !busy && !sqrt_ack;
    assign sqrt_out = {{(WORD_W - SQRT_ITER){1'b0}}, root};

    // Non-restoring step, sign of the remainder picks add or subtract
    always_comb begin
        rem_sh = {rem[SQRT_REM_W-3:0], rad[2*SQRT_ITER-1 -: 2]};
        if (rem[SQRT_REM_W-1]) begin
            rem_nx = rem_sh + SQRT_REM_W'({root, 2'b11});
        end else begin
            rem_nx = rem_sh - SQRT_REM_W'({root, 2'b01});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            sqrt_ack <= 1'b0;
            cnt      <= '0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == '0) begin
                busy     <= 1'b0;
                sqrt_ack <= 1'b1;
            end
        end else if (sqrt_ack) begin
            if (!sqrt_req) begin
                sqrt_ack <= 1'b0;
            end
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= SQRT_CNT_W'(SQRT_ITER - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad  <= (sqrt_in > 0) ? {sqrt_in, {FRAC_BITS{1'b0}}} : '0;  // Non-positive gives 0
            rem  <= '0;
            root <= '0;
        end else if (busy) begin
            rad  <= rad << 2;
            rem  <= rem_nx;
            root <= {root[SQRT_ITER-2:0], ~rem_nx[SQRT_REM_W-1]};
        end
    end

endmodule

//--- verilog/fix_div.sv
module fix_div
    import chol_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    div_req,
    input  div_op_t div_op,
    output logic    div_ack,
    output word_t   div_out
);

    logic                 busy;
    logic                 start;
    logic [DIV_CNT_W-1:0] cnt;
    logic [WORD_W-1:0]    mag;     // Dividend magnitude
    logic [DIV_ITER-1:0]  num;     // Shifted dividend, quotient fills from the bottom
    logic [WORD_W-1:0]    rem;
    logic [WORD_W:0]      rem_sh;
    logic [WORD_W:0]      diff;
    logic                 neg;
    word_t                quo;

    assign start = div_req && !busy && !div_ack;
    assign mag   = div_op.dividend[WORD_W-1] ? -div_op.dividend : div_op.dividend;

    // Trial subtract, top bit set means borrow
    assign rem_sh = {rem, num[DIV_ITER-1]};
    assign diff   = rem_sh - {1'b0, div_op.divisor};

    // Sign back on the magnitude quotient
    assign quo     = num[WORD_W-1:0];
    assign div_out = neg ? -quo : quo;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            div_ack <= 1'b0;
            cnt     <= '0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == '0) begin
                busy    <= 1'b0;
                div_ack <= 1'b1;
            end
        end else if (div_ack) begin
            if (!div_req) begin
                div_ack <= 1'b0;
            end
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= DIV_CNT_W'(DIV_ITER - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            num <= {mag, {FRAC_BITS{1'b0}}};
            rem <= '0;
            neg <= div_op.dividend[WORD_W-1];
        end else if (busy) begin
            // Restore on borrow, otherwise keep the difference
            rem <= diff[WORD_W] ? rem_sh[WORD_W-1:0] : diff[WORD_W-1:0];
            num <= {num[DIV_ITER-2:0], ~diff[WORD_W]};
        end
    end

endmodule

//--- verilog/dot_acc.sv
module dot_acc
    import chol_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  acc_clear,
    input  logic  acc_en,
    input  word_t base,
    input  word_t acc_x,
    input  word_t acc_y,
    output word_t resid
);

    acc_t  sum;      // Running sum of full products
    acc_t  prod;
    acc_t  sum_nx;
    acc_t  shifted;
    word_t base_q;

    assign prod    = acc_x * acc_y;
    assign sum_nx  = sum + prod;
    assign shifted = sum_nx >>> FRAC_BITS;  // Scale once, after summing

    always_ff @(posedge clk) begin
        if (rst) begin
            sum   <= '0;
            resid <= '0;
        end else if (acc_clear) begin
            sum   <= '0;
            resid <= base;  // No products yet
        end else if (acc_en) begin
            sum   <= sum_nx;
            resid <= base_q - shifted[WORD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (acc_clear) begin
            base_q <= base;
        end
    end

endmodule

//--- verilog/chol_ctrl.sv
module chol_ctrl
    import chol_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  tri_mat_t a,
    input  logic     a_req,
    output logic     a_ack,
    output tri_mat_t l,
    output logic     not_pd,
    output logic     sqrt_req,
    output word_t    sqrt_in,
    input  logic     sqrt_ack,
    input  word_t    sqrt_out,
    output logic     div_req,
    output div_op_t  div_op,
    input  logic     div_ack,
    input  word_t    div_out,
    output logic     acc_clear,
    output logic     acc_en,
    output word_t    base,
    output word_t    acc_x,
    output word_t    acc_y,
    input  word_t    resid
);

    typedef enum logic [2:0] {
        S_IDLE,   // Waiting for a matrix
        S_CLEAR,  // Load A element into the accumulator
        S_ACC,    // Stream L products, one per cycle
        S_WAIT,   // Residual ready, hand it to a unit
        S_SQRT,   // Diagonal square root running
        S_DRAIN,  // Last divide of the column still running
        S_DONE    // Result held with a_ack
    } state_t;

    state_t           state;
    tri_mat_t         a_reg;
    logic [RC_W-1:0]  row;
    logic [RC_W-1:0]  col;
    logic [RC_W-1:0]  k;
    logic [IDX_W-1:0] div_idx;    // Where the pending quotient goes
    logic             start;
    logic             diag;
    logic             last_row;
    logic             last_col;
    logic             div_free;
    logic             issue_sqrt;
    logic             issue_div;

    assign start      = (state == S_IDLE) && a_req;
    assign diag       = (row == col);
    assign last_row   = (row == RC_W'(N - 1));
    assign last_col   = (col == RC_W'(N - 1));
    assign div_free   = !div_req && !div_ack; // Divider back to idle
    assign issue_sqrt = (state == S_WAIT) && diag && (resid > 0) && !sqrt_ack;
    assign issue_div  = (state == S_WAIT) && !diag && div_free;

    // ====================
    // Accumulator feed
    // ====================
    assign acc_clear = (state == S_CLEAR);
    assign acc_en    = (state == S_ACC);
    assign base      = a_reg[tri_idx(row, col)];
    assign acc_x     = l[tri_idx(row, k)];  // L_ik
    assign acc_y     = l[tri_idx(col, k)];  // L_jk

    // ====================
    // Column sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            a_ack    <= 1'b0;
            not_pd   <= 1'b0;
            l        <= '0;
            sqrt_req <= 1'b0;
            div_req  <= 1'b0;
            row      <= '0;
            col      <= '0;
            k        <= '0;
        end else begin
            // A quotient may come back while the next row accumulates
            if (div_req && div_ack) begin
                l[div_idx] <= div_out;
                div_req    <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        l      <= '0;  // Anything not reached stays zero
                        not_pd <= 1'b0;
                        row    <= '0;
                        col    <= '0;
                        state  <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    k     <= '0;
                    state <= (col == '0) ? S_WAIT : S_ACC;  // First column has no products
                end
                S_ACC: begin
                    k <= k + 1'b1;
                    if (k == col - 1'b1) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (diag) begin
                        if (!(resid > 0)) begin
                            not_pd <= 1'b1;  // Not positive definite, stop here
                            a_ack  <= 1'b1;
                            state  <= S_DONE;
                        end else if (issue_sqrt) begin
                            sqrt_req <= 1'b1;
                            state    <= S_SQRT;
                        end
                    end else if (issue_div) begin
                        div_req <= 1'b1;
                        if (last_row) begin
                            state <= S_DRAIN;
                        end else begin
                            row   <= row + 1'b1;
                            state <= S_CLEAR;
                        end
                    end
                end
                S_SQRT: begin
                    if (sqrt_ack) begin
                        l[tri_idx(col, col)] <= sqrt_out;
                        sqrt_req             <= 1'b0;
                        if (last_col) begin
                            a_ack <= 1'b1;
                            state <= S_DONE;
                        end else begin
                            row   <= col + 1'b1;
                            state <= S_CLEAR;
                        end
                    end
                end
                S_DRAIN: begin
                    // Next diagonal needs every L of this column
                    if (div_free) begin
                        col   <= col + 1'b1;
                        row   <= col + 1'b1;
                        state <= S_CLEAR;
                    end
                end
                S_DONE: begin
                    if (!a_req) begin
                        a_ack <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Operand registers, stable for the whole handshake
    always_ff @(posedge clk) begin
        if (start) begin
            a_reg <= a;
        end
        if (issue_sqrt) begin
            sqrt_in <= resid;
        end
        if (issue_div) begin
            div_op.dividend <= resid;
            div_op.divisor  <= l[tri_idx(col, col)];  // L_jj
            div_idx         <= tri_idx(row, col);
        end
    end

endmodule

//--- verilog/cholesky_top.sv
module cholesky_top
    import chol_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  tri_mat_t a,
    input  logic     a_req,
    output logic     a_ack,
    output tri_mat_t l,
    output logic     not_pd
);

    // ====================
    // Unit links
    // ====================
    logic    sqrt_req;
    logic    sqrt_ack;
    word_t   sqrt_in;
    word_t   sqrt_out;
    logic    div_req;
    logic    div_ack;
    div_op_t div_op;
    word_t   div_out;
    logic    acc_clear;
    logic    acc_en;
    word_t   base;
    word_t   acc_x;
    word_t   acc_y;
    word_t   resid;

    chol_ctrl i_chol_ctrl (
        .clk       (clk),
        .rst       (rst),
        .a         (a),
        .a_req     (a_req),
        .a_ack     (a_ack),
        .l         (l),
        .not_pd    (not_pd),
        .sqrt_req  (sqrt_req),
        .sqrt_in   (sqrt_in),
        .sqrt_ack  (sqrt_ack),
        .sqrt_out  (sqrt_out),
        .div_req   (div_req),
        .div_op    (div_op),
        .div_ack   (div_ack),
        .div_out   (div_out),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .base      (base),
        .acc_x     (acc_x),
        .acc_y     (acc_y),
        .resid     (resid)
    );

    fix_sqrt i_fix_sqrt (
        .clk      (clk),
        .rst      (rst),
        .sqrt_req (sqrt_req),
        .sqrt_in  (sqrt_in),
        .sqrt_ack (sqrt_ack),
        .sqrt_out (sqrt_out)
    );

    fix_div i_fix_div (
        .clk     (clk),
        .rst     (rst),
        .div_req (div_req),
        .div_op  (div_op),
        .div_ack (div_ack),
        .div_out (div_out)
    );

    dot_acc i_dot_acc (
        .clk       (clk),
        .rst       (rst),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .base      (base),
        .acc_x     (acc_x),
        .acc_y     (acc_y),
        .resid     (resid)
    );

endmodule

//--- test/chol_chk.sv
module chol_chk (
    input logic clk,
    input logic rst,
    input logic a_req,
    input logic a_ack,
    input logic sqrt_req,
    input logic sqrt_ack,
    input logic div_req,
    input logic div_ack
);

    int unsigned fail_cnt = 0;  // Failed assertions so far

    // ====================
    // Unit handshakes
    // ====================
    sqrt_hold: assert property (@(posedge clk) disable iff (rst)
        sqrt_req && !sqrt_ack |=> sqrt_req)
        else begin
            fail_cnt++;
            $error("sqrt_req dropped before sqrt_ack");
        end

    div_hold: assert property (@(posedge clk) disable iff (rst)
        div_req && !div_ack |=> div_req)
        else begin
            fail_cnt++;
            $error("div_req dropped before div_ack");
        end

    div_excl: assert property (@(posedge clk) disable iff (rst)
        $rose(div_req) |-> !sqrt_req)
        else begin
            fail_cnt++;
            $error("div_req rose while sqrt_req was high");
        end

    // Top level four-phase return
    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(a_ack) |-> !$past(a_req))
        else begin
            fail_cnt++;
            $error("a_ack fell while a_req was still high");
        end

endmodule

bind chol_ctrl chol_chk i_chol_chk (
    .clk      (clk),
    .rst      (rst),
    .a_req    (a_req),
    .a_ack    (a_ack),
    .sqrt_req (sqrt_req),
    .sqrt_ack (sqrt_ack),
    .div_req  (div_req),
    .div_ack  (div_ack)
);

//--- test/tb_cholesky.sv
module tb_cholesky
    import chol_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 32'h305d_0b19;
    localparam int NUM_DIAG   = 6;
    localparam int NUM_PD     = 200;
    localparam int NUM_BAD    = 15;         // Per kind of failing matrix
    localparam int NUM_RUNS   = 1 + NUM_DIAG + NUM_PD + 2 * NUM_BAD;
    localparam int MAX_LAT    = NUM_ELEM * 60 + 200;
    localparam int ONE        = 1 << FRAC_BITS;
    localparam int B_MAX      = 2 << FRAC_BITS;  // Entries of B within +-2.0

    logic     clk;
    logic     rst;
    tri_mat_t a;
    logic     a_req;
    logic     a_ack;
    tri_mat_t l;
    logic     not_pd;
    tri_mat_t m;

    cholesky_top i_cholesky_top (
        .clk    (clk),
        .rst    (rst),
        .a      (a),
        .a_req  (a_req),
        .a_ack  (a_ack),
        .l      (l),
        .not_pd (not_pd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_RUNS * MAX_LAT + 20) * CLK_PERIOD);
        $display("watchdog: the run did not finish in the expected time");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    // Handshake assertions bound into the controller
    initial begin
        wait (i_cholesky_top.i_chol_ctrl.i_chol_chk.fail_cnt != 0);
        abort_run("a handshake assertion in chol_ctrl failed");
    end

    // ====================
    // Reporting
    // ====================
    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("error: time %0t signal %s expected %0h actual %0h", $time, name, exp, got);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("error: time %0t %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic int tidx(input int i, input int j);
        return i * (i + 1) / 2 + j;  // 0-based row and column
    endfunction

    function automatic word_t at(input tri_mat_t t, input int i, input int j);
        return t[tidx(i, j)];
    endfunction

    function automatic word_t residual(input word_t b, input longint sum);
        return word_t'(longint'(b) - (sum >>> FRAC_BITS));
    endfunction

    function automatic word_t root_q(input word_t x);
        longint unsigned v;
        longint unsigned r;
        longint unsigned t;
        if (x <= 0) begin
            return '0;
        end
        v = longint'(x) <<< FRAC_BITS;
        r = 0;
        for (int b = SQRT_ITER - 1; b >= 0; b--) begin
            t = r | (64'd1 << b);
            if (t * t <= v) begin
                r = t;
            end
        end
        return word_t'(r);
    endfunction

    function automatic word_t quot_q(input word_t n, input word_t d);
        longint q;
        q = (longint'(n) <<< FRAC_BITS) / longint'(d);  // Truncates toward zero
        return word_t'(q);
    endfunction

    task automatic factor_model(input tri_mat_t am, output tri_mat_t el, output logic npd);
        longint sum;
        word_t  r;
        el  = '0;
        npd = 1'b0;
        for (int j = 0; j < N && !npd; j++) begin
            sum = 0;
            for (int k = 0; k < j; k++) begin
                sum += longint'(at(el, j, k)) * longint'(at(el, j, k));
            end
            r = residual(at(am, j, j), sum);
            if (r <= 0) begin
                npd = 1'b1;  // Rest of L stays zero
            end else begin
                el[tidx(j, j)] = root_q(r);
                for (int i = j + 1; i < N; i++) begin
                    sum = 0;
                    for (int k = 0; k < j; k++) begin
                        sum += longint'(at(el, i, k)) * longint'(at(el, j, k));
                    end
                    el[tidx(i, j)] = quot_q(residual(at(am, i, j), sum), at(el, j, j));
                end
            end
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    // B times B transposed, plus a positive diagonal unless a row of B is zeroed
    task automatic build_matrix(output tri_mat_t t, input int zero_row);
        int     b [N][N];
        longint s;
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                b[i][k] = (i == zero_row) ? 0 : int'($urandom_range(2 * B_MAX)) - B_MAX;
            end
        end
        t = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                s = 0;
                for (int k = 0; k < N; k++) begin
                    s += longint'(b[i][k]) * longint'(b[j][k]);
                end
                t[tidx(i, j)] = word_t'(s >>> FRAC_BITS);
            end
        end
        if (zero_row < 0) begin
            for (int i = 0; i < N; i++) begin
                t[tidx(i, i)] = at(t, i, i) + word_t'($urandom_range(4 * ONE, ONE / 4));
            end
        end
    endtask

    task automatic compare_l(input tri_mat_t exp);
        word_t e;
        word_t g;
        for (int i = 0; i < NUM_ELEM; i++) begin
            e = exp[i];
            g = l[i];
            assert (g == e) else report_mismatch($sformatf("l[%0d]", i), e, g);
        end
    endtask

    task automatic run_matrix(input tri_mat_t t, input logic want_npd);
        tri_mat_t exp_l;
        tri_mat_t held;
        logic     exp_npd;
        int       waited;
        int       hold;
        factor_model(t, exp_l, exp_npd);
        assert (exp_npd == want_npd)
            else abort_run("test matrix does not have the intended definiteness");
        hold = $urandom_range(8);
        @(posedge clk);
        a     <= t;
        a_req <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!a_ack) begin
            waited++;
            assert (waited < MAX_LAT) else abort_run("a_ack did not rise in time");
            @(negedge clk);
        end
        compare_l(exp_l);
        assert (not_pd == exp_npd) else report_mismatch("not_pd", exp_npd, not_pd);
        held = l;
        repeat (hold) begin  // Back-pressure on the return phase
            @(negedge clk);
            assert (a_ack) else abort_run("a_ack fell while a_req was still high");
            compare_l(held);
        end
        @(posedge clk);
        a_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (a_ack) begin
            waited++;
            assert (waited < 8) else abort_run("a_ack did not fall after a_req was lowered");
            compare_l(held);
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst   = 1'b1;
        a_req = 1'b0;
        a     = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (a_ack == 1'b0) else report_mismatch("a_ack", 0, a_ack);
        assert (not_pd == 1'b0) else report_mismatch("not_pd", 0, not_pd);
        compare_l('0);

        m = '0;
        for (int i = 0; i < N; i++) begin
            m[tidx(i, i)] = ONE;
        end
        run_matrix(m, 1'b0);
        compare_l(m);  // Identity factors to itself

        repeat (NUM_DIAG) begin
            m = '0;
            for (int i = 0; i < N; i++) begin
                m[tidx(i, i)] = word_t'($urandom_range(8 * ONE, 1 << 12));
            end
            run_matrix(m, 1'b0);
        end

        repeat (NUM_PD) begin
            build_matrix(m, -1);
            run_matrix(m, 1'b0);
        end

        repeat (NUM_BAD) begin
            int r;
            r = $urandom_range(N - 1);
            build_matrix(m, -1);
            m[tidx(r, r)] = -word_t'($urandom_range(4 * ONE, 1));
            run_matrix(m, 1'b1);
        end

        repeat (NUM_BAD) begin
            build_matrix(m, $urandom_range(N - 1));  // Rank deficient
            run_matrix(m, 1'b1);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- compile.f
verilog/chol_pkg.sv
verilog/fix_sqrt.sv
verilog/fix_div.sv
verilog/dot_acc.sv
verilog/chol_ctrl.sv
verilog/cholesky_top.sv
test/chol_chk.sv
test/tb_cholesky.sv
